// File: logic/mmio_map_pkg.sv
package mmio_map_pkg;

    // single-word register addresses seen by the memory handler
    localparam logic [31:0] SPI_CMD_ADDR   = 32'd121212;  // spi command byte + byte count
    localparam logic [31:0] SPI_PARAM_ADDR = 32'd333333;  // spi parameter word, write starts shift
    localparam logic [31:0] TOUCH_ADDR     = 32'd923923;  // last xy word from the i2c reader

    // everything strictly below this byte address lives in the data sram
    localparam logic [31:0] SRAM_LIMIT = 32'd2048;

    // decoder FSM
    //   IDLE     accept a command, or stall in place with busy high
    //   MEM_WAIT sram read issued, data not back yet
    //   DONE     last busy cycle, busy drops on exit
    typedef enum logic [1:0] {
        IDLE,
        MEM_WAIT,
        DONE
    } dec_state_t;

endpackage

// File: logic/spi_reg_pkg.sv
package spi_reg_pkg;

    // the parameter word carries at most four bytes
    localparam int SPI_MAX_BYTES = 4;

    // command register contents, count sits above the command byte
    typedef struct packed {
        logic [3:0] count;  // parameter bytes to send, 0..4
        logic [7:0] cmd;    // first byte on the wire
    } spi_cmd_t;

    // write word as seen at the command register address
    typedef struct packed {
        logic [19:0] rsvd;  // ignored
        spi_cmd_t    cmd;
    } spi_cmd_word_t;

    // one handler write word, read either way depending on the target address
    typedef union packed {
        spi_cmd_word_t cmd_word;  // SPI_CMD_ADDR
        logic [31:0]   param;     // SPI_PARAM_ADDR
    } handler_word_u;

endpackage

// File: logic/touch_latch.sv
`timescale 1ns/10ps

module touch_latch (
    input  logic        clk,
    input  logic        nRst,
    input  logic [31:0] i2c_xy_i,     // coordinate from the i2c reader
    input  logic        i2c_done_i,   // one-cycle pulse, new xy present
    input  logic        take_i,       // decoder has returned the xy
    output logic [31:0] xy_o,
    output logic        valid_o
);

    // newest coordinate overwrites an unread one
    always_ff @(posedge clk) begin
        if (i2c_done_i)
            xy_o <= i2c_xy_i;
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            valid_o <= 1'b0;
        end else if (i2c_done_i) begin
            valid_o <= 1'b1;   // fresh data wins over a take
        end else if (take_i) begin
            valid_o <= 1'b0;
        end
    end

    // decoder only consumes a coordinate that is there
    a_take_when_valid: assert property (@(posedge clk) disable iff (!nRst)
        take_i |-> valid_o);

endmodule

// File: logic/data_sram.sv
`timescale 1ns/10ps

module data_sram #(
    parameter int SRAM_WORDS = 512
) (
    input  logic        clk,
    input  logic        nRst,
    input  logic        read_i,
    input  logic        write_i,
    input  logic [31:0] addr_i,    // byte address, low two bits dropped
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        busy_o
);

    localparam int AW = $clog2(SRAM_WORDS);

    logic [31:0]   mem [SRAM_WORDS];
    logic [AW-1:0] word_idx;

    assign word_idx = addr_i[AW+1:2];

    // full words only, no byte lanes
    always_ff @(posedge clk) begin
        if (write_i)
            mem[word_idx] <= wdata_i;
        if (read_i)
            rdata_o <= mem[word_idx];   // data one cycle after the strobe
    end

    // recovery cycle after every access
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            busy_o <= 1'b0;
        end else begin
            busy_o <= read_i || write_i;
        end
    end

    // decoder has to honour the recovery cycle
    a_no_access_busy: assert property (@(posedge clk) disable iff (!nRst)
        busy_o |-> !(read_i || write_i));

    a_addr_in_range: assert property (@(posedge clk) disable iff (!nRst)
        (read_i || write_i) |-> (addr_i < 32'(SRAM_WORDS * 4)));

endmodule

// File: logic/spi_shifter.sv
`timescale 1ns/10ps

module spi_shifter #(
    parameter int SPI_CLK_DIV = 4   // system clocks per sclk half period
) (
    input  logic                  clk,
    input  logic                  nRst,
    input  logic                  start_i,
    input  spi_reg_pkg::spi_cmd_t cmd_i,
    input  logic [31:0]           param_i,
    output logic                  busy_o,
    output logic                  sclk_o,
    output logic                  mosi_o,
    output logic                  cs_n_o
);
    import spi_reg_pkg::*;

    localparam int SREG_W = 8 * (SPI_MAX_BYTES + 1);   // command byte + params
    localparam int DW     = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;

    logic [SREG_W-1:0] sreg;
    logic [DW-1:0]     div_cnt;
    logic [5:0]        bits_left;
    logic [3:0]        n_bytes;
    logic [SREG_W-1:0] load_word;
    logic [5:0]        load_bits;
    logic              load, half_tick, fall_edge;

    assign load      = start_i && !busy_o;
    assign half_tick = busy_o && (div_cnt == DW'(SPI_CLK_DIV - 1));
    assign fall_edge = half_tick && sclk_o;   // next bit goes out here

    // left-justify the counted low bytes of the parameter behind the command
    always_comb begin
        if (cmd_i.count > 4'(SPI_MAX_BYTES))
            n_bytes = 4'(SPI_MAX_BYTES);
        else
            n_bytes = cmd_i.count;
        load_word = {cmd_i.cmd, param_i << (8 * (SPI_MAX_BYTES - int'(n_bytes)))};
        load_bits = 6'(8 * (int'(n_bytes) + 1));
    end

    always_ff @(posedge clk) begin
        if (load)
            sreg <= load_word;
        else if (fall_edge)
            sreg <= {sreg[SREG_W-2:0], 1'b0};
    end

    // mode 0 with sclk idling low
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            busy_o    <= 1'b0;
            cs_n_o    <= 1'b1;
            sclk_o    <= 1'b0;
            mosi_o    <= 1'b0;
            div_cnt   <= '0;
            bits_left <= '0;
        end else if (load) begin
            busy_o    <= 1'b1;
            cs_n_o    <= 1'b0;
            sclk_o    <= 1'b0;
            mosi_o    <= cmd_i.cmd[7];   // msb ready before the first rise
            div_cnt   <= '0;
            bits_left <= load_bits;
        end else if (busy_o) begin
            if (half_tick) begin
                div_cnt <= '0;
                if (!sclk_o) begin
                    sclk_o <= 1'b1;   // slave samples
                end else begin
                    sclk_o <= 1'b0;
                    if (bits_left == 6'd1) begin
                        busy_o    <= 1'b0;   // last bit is out
                        cs_n_o    <= 1'b1;
                        mosi_o    <= 1'b0;
                        bits_left <= '0;
                    end else begin
                        mosi_o    <= sreg[SREG_W-2];
                        bits_left <= bits_left - 6'd1;
                    end
                end
            end else begin
                div_cnt <= div_cnt + DW'(1);
            end
        end
    end

    // decoder must hold off parameter writes until the shift ends
    a_start_not_busy: assert property (@(posedge clk) disable iff (!nRst)
        start_i |-> !busy_o);

endmodule

// File: logic/mmio_decoder.sv
`timescale 1ns/10ps

module mmio_decoder (
    input  logic                 clk,
    input  logic                 nRst,
    // memory handler side
    input  logic                 read_i,
    input  logic                 write_i,
    input  logic [31:0]          address_i,
    input  logic [31:0]          wdata_i,
    output logic [31:0]          rdata_o,
    output logic                 busy_o,
    // data sram
    input  logic [31:0]          mem_rdata_i,
    input  logic                 mem_busy_i,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output logic [31:0]          mem_addr_o,
    output logic [31:0]          mem_wdata_o,
    // spi master
    input  logic                 spi_busy_i,
    output spi_reg_pkg::spi_cmd_t spi_cmd_o,
    output logic [31:0]          spi_param_o,
    output logic                 spi_start_o,
    // touch latch
    input  logic [31:0]          touch_xy_i,
    input  logic                 touch_valid_i,
    output logic                 touch_take_o
);
    import mmio_map_pkg::*;
    import spi_reg_pkg::*;

    dec_state_t    state, state_next;
    logic          rest, rest_next;            // one idle cycle after busy falls
    logic          mem_rd_pend, mem_rd_pend_next;  // DONE must grab sram data
    logic          busy_next;
    logic          mem_read_next, mem_write_next;
    logic          spi_start_next, touch_take_next;
    spi_cmd_t      spi_cmd_next;
    logic [31:0]   rdata_next, mem_addr_next, mem_wdata_next, spi_param_next;
    handler_word_u hword;
    logic          rd_cmd, wr_cmd, in_sram;

    assign hword   = wdata_i;
    assign rd_cmd  = read_i && !write_i;   // both or neither is ignored
    assign wr_cmd  = write_i && !read_i;
    assign in_sram = address_i < SRAM_LIMIT;

    always_comb begin
        state_next       = state;
        rest_next        = 1'b0;
        mem_rd_pend_next = 1'b0;
        busy_next        = 1'b0;
        mem_read_next    = 1'b0;
        mem_write_next   = 1'b0;
        spi_start_next   = 1'b0;
        touch_take_next  = 1'b0;
        spi_cmd_next     = spi_cmd_o;   // held between command writes
        rdata_next       = rdata_o;
        mem_addr_next    = mem_addr_o;
        mem_wdata_next   = mem_wdata_o;
        spi_param_next   = spi_param_o;

        case (state)
            IDLE: begin
                if (rest) begin
                    busy_next = 1'b0;   // handler drops its command here
                end else if (rd_cmd) begin
                    busy_next = 1'b1;
                    if (address_i == TOUCH_ADDR) begin
                        if (touch_valid_i) begin   // otherwise stall
                            rdata_next      = touch_xy_i;
                            touch_take_next = 1'b1;
                            state_next      = DONE;
                        end
                    end else if (in_sram) begin
                        if (!mem_busy_i) begin
                            mem_read_next = 1'b1;
                            mem_addr_next = address_i;
                            state_next    = MEM_WAIT;
                        end
                    end else begin
                        rdata_next = '0;   // unmapped, registers are write only
                        state_next = DONE;
                    end
                end else if (wr_cmd) begin
                    busy_next = 1'b1;
                    if (address_i == SPI_CMD_ADDR) begin
                        spi_cmd_next = hword.cmd_word.cmd;
                        state_next   = DONE;
                    end else if (address_i == SPI_PARAM_ADDR) begin
                        if (!spi_busy_i) begin
                            spi_param_next = hword.param;
                            spi_start_next = 1'b1;
                            state_next     = DONE;
                        end
                    end else if (in_sram) begin
                        if (!mem_busy_i) begin
                            mem_write_next = 1'b1;
                            mem_addr_next  = address_i;
                            mem_wdata_next = wdata_i;
                            state_next     = DONE;
                        end
                    end else begin
                        state_next = DONE;   // dropped write
                    end
                end
            end
            MEM_WAIT: begin
                busy_next        = 1'b1;
                mem_rd_pend_next = 1'b1;
                state_next       = DONE;
            end
            DONE: begin
                if (mem_rd_pend)
                    rdata_next = mem_rdata_i;   // registered sram read lands now
                rest_next  = 1'b1;
                state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= IDLE;
            rest         <= 1'b0;
            mem_rd_pend  <= 1'b0;
            busy_o       <= 1'b0;
            mem_read_o   <= 1'b0;
            mem_write_o  <= 1'b0;
            spi_start_o  <= 1'b0;
            touch_take_o <= 1'b0;
            spi_cmd_o    <= '0;
        end else begin
            state        <= state_next;
            rest         <= rest_next;
            mem_rd_pend  <= mem_rd_pend_next;
            busy_o       <= busy_next;
            mem_read_o   <= mem_read_next;
            mem_write_o  <= mem_write_next;
            spi_start_o  <= spi_start_next;
            touch_take_o <= touch_take_next;
            spi_cmd_o    <= spi_cmd_next;
        end
    end

    always_ff @(posedge clk) begin
        rdata_o     <= rdata_next;
        mem_addr_o  <= mem_addr_next;
        mem_wdata_o <= mem_wdata_next;
        spi_param_o <= spi_param_next;
    end

    a_mem_one_strobe: assert property (@(posedge clk) disable iff (!nRst)
        !(mem_read_o && mem_write_o));

    // a new transfer may only start once the shifter has let go
    a_spi_start_idle: assert property (@(posedge clk) disable iff (!nRst)
        $rose(spi_start_o) |-> !spi_busy_i);

endmodule

// File: logic/mmio_subsystem.sv
`timescale 1ns/10ps

module mmio_subsystem #(
    parameter int SRAM_WORDS  = 512,
    parameter int SPI_CLK_DIV = 4
) (
    input  logic        clk,
    input  logic        nRst,
    // memory handler
    input  logic        read_i,
    input  logic        write_i,
    input  logic [31:0] address_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        busy_o,
    // i2c reader
    input  logic [31:0] i2c_xy_i,
    input  logic        i2c_done_i,
    output logic        i2c_pending_o,   // unread coordinate waiting
    // spi pins
    output logic        spi_sclk_o,
    output logic        spi_mosi_o,
    output logic        spi_cs_n_o
);
    import spi_reg_pkg::*;

    logic [31:0] mem_rdata, mem_addr, mem_wdata;
    logic        mem_busy, mem_read, mem_write;
    spi_cmd_t    spi_cmd;
    logic [31:0] spi_param;
    logic        spi_start, spi_busy;
    logic [31:0] touch_xy;
    logic        touch_take;

    mmio_decoder i_decoder (
        .clk          (clk),
        .nRst         (nRst),
        .read_i       (read_i),
        .write_i      (write_i),
        .address_i    (address_i),
        .wdata_i      (wdata_i),
        .rdata_o      (rdata_o),
        .busy_o       (busy_o),
        .mem_rdata_i  (mem_rdata),
        .mem_busy_i   (mem_busy),
        .mem_read_o   (mem_read),
        .mem_write_o  (mem_write),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .spi_busy_i   (spi_busy),
        .spi_cmd_o    (spi_cmd),
        .spi_param_o  (spi_param),
        .spi_start_o  (spi_start),
        .touch_xy_i   (touch_xy),
        .touch_valid_i(i2c_pending_o),
        .touch_take_o (touch_take)
    );

    data_sram #(.SRAM_WORDS(SRAM_WORDS)) i_sram (
        .clk    (clk),
        .nRst   (nRst),
        .read_i (mem_read),
        .write_i(mem_write),
        .addr_i (mem_addr),
        .wdata_i(mem_wdata),
        .rdata_o(mem_rdata),
        .busy_o (mem_busy)
    );

    spi_shifter #(.SPI_CLK_DIV(SPI_CLK_DIV)) i_spi (
        .clk    (clk),
        .nRst   (nRst),
        .start_i(spi_start),
        .cmd_i  (spi_cmd),
        .param_i(spi_param),
        .busy_o (spi_busy),
        .sclk_o (spi_sclk_o),
        .mosi_o (spi_mosi_o),
        .cs_n_o (spi_cs_n_o)
    );

    touch_latch i_touch (
        .clk       (clk),
        .nRst      (nRst),
        .i2c_xy_i  (i2c_xy_i),
        .i2c_done_i(i2c_done_i),
        .take_i    (touch_take),
        .xy_o      (touch_xy),
        .valid_o   (i2c_pending_o)
    );

endmodule

// File: include/tb_mmio_checks.svh
`ifndef TB_MMIO_CHECKS_SVH
`define TB_MMIO_CHECKS_SVH

localparam int BUSY_TIMEOUT = 200;   // clocks allowed for any busy edge

int err_count   = 0;
int check_count = 0;

// fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

task automatic check_value(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("Fail %s: expected %h, actual %h", what, exp, got);
    end
endtask

// wait until busy_o shows the given level, gives up after BUSY_TIMEOUT clocks
task automatic wait_busy(input logic level, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < BUSY_TIMEOUT; n++) begin
        @(posedge clk);
        if (busy_o === level) begin
            ok = 1'b1;
            break;
        end
    end
endtask

task automatic handler_cmd(input logic rd, input logic [31:0] addr,
                           input logic [31:0] data, output logic [31:0] rdata);
    bit ok;
    @(posedge clk);
    read_i    <= rd;
    write_i   <= !rd;
    address_i <= addr;
    wdata_i   <= data;
    wait_busy(1'b1, ok);
    if (!ok) begin
        err_count++;
        $display("busy never rose for the command at address %h", addr);
    end
    wait_busy(1'b0, ok);
    if (!ok) begin
        err_count++;
        $display("busy never fell for the command at address %h", addr);
    end
    rdata   = rdata_o;
    read_i  <= 1'b0;   // dropped in the idle cycle after busy
    write_i <= 1'b0;
endtask

task automatic handler_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    handler_cmd(1'b0, addr, data, unused);
endtask

task automatic handler_read(input logic [31:0] addr, output logic [31:0] data);
    handler_cmd(1'b1, addr, 32'h0, data);
endtask

`endif

// File: testbench/tb_mmio_subsystem.sv
`timescale 1ns/10ps

module tb_mmio_subsystem;
    import mmio_map_pkg::*;

    localparam int SPI_TIMEOUT = 600;   // clocks allowed for one spi frame

    logic        clk;
    logic        nRst;
    logic        read_i, write_i;
    logic [31:0] address_i, wdata_i, rdata_o;
    logic        busy_o;
    logic [31:0] i2c_xy_i;
    logic        i2c_done_i, i2c_pending_o;
    logic        spi_sclk_o, spi_mosi_o, spi_cs_n_o;

    logic [31:0] lfsr_state = 32'h8044_f10e;
    logic [31:0] sram_sb [logic [31:0]];   // expected sram words by byte address
    dec_state_t  dec_state;                // decoder state by name in the wave viewer

    `include "tb_mmio_checks.svh"

    mmio_subsystem #(.SRAM_WORDS(512), .SPI_CLK_DIV(2)) i_dut (
        .clk          (clk),
        .nRst         (nRst),
        .read_i       (read_i),
        .write_i      (write_i),
        .address_i    (address_i),
        .wdata_i      (wdata_i),
        .rdata_o      (rdata_o),
        .busy_o       (busy_o),
        .i2c_xy_i     (i2c_xy_i),
        .i2c_done_i   (i2c_done_i),
        .i2c_pending_o(i2c_pending_o),
        .spi_sclk_o   (spi_sclk_o),
        .spi_mosi_o   (spi_mosi_o),
        .spi_cs_n_o   (spi_cs_n_o)
    );

    assign dec_state = i_dut.i_decoder.state;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // shift in mosi on every sclk rise of one cs_n frame
    task automatic collect_spi(output logic [63:0] stream, output int nbits, output time end_t);
        logic prev_sclk;
        bit   started;
        stream    = '0;
        nbits     = 0;
        end_t     = 0;
        started   = 1'b0;
        prev_sclk = 1'b0;
        for (int n = 0; n < SPI_TIMEOUT; n++) begin
            @(posedge clk);
            if (!started && spi_cs_n_o === 1'b0)
                started = 1'b1;
            if (started) begin
                if (spi_cs_n_o === 1'b1) begin
                    end_t = $time;   // frame closed
                    break;
                end
                if (spi_sclk_o === 1'b1 && prev_sclk === 1'b0) begin
                    stream = {stream[62:0], spi_mosi_o};
                    nbits++;
                end
            end
            prev_sclk = spi_sclk_o;
        end
        if (end_t == 0) begin
            err_count++;
            $display("spi frame never started or cs_n never went back high");
        end
    endtask

    // command byte first, then the low cnt bytes of the parameter, msb first
    task automatic check_spi_frame(input string name, input logic [7:0] cmd, input int cnt,
                                   input logic [31:0] param, input logic [63:0] stream,
                                   input int nbits);
        logic [63:0] mask, shifted;
        mask    = (64'd1 << (8 * cnt)) - 64'd1;
        shifted = stream >> (8 * cnt);
        check_value({name, " bits"}, nbits, 8 * (cnt + 1));
        check_value({name, " cmd"}, {24'd0, shifted[7:0]}, {24'd0, cmd});
        check_value({name, " param"}, stream[31:0] & mask[31:0], param & mask[31:0]);
        check_value({name, " cs_n"}, spi_cs_n_o, 1'b1);
    endtask

    task automatic check_sram_contents(input string name);
        logic [31:0] d;
        foreach (sram_sb[a]) begin
            handler_read(a, d);
            check_value($sformatf("%s @%h", name, a), d, sram_sb[a]);
        end
    endtask

    task automatic test_reset_values();
        check_value("reset busy", busy_o, 1'b0);
        check_value("reset cs_n", spi_cs_n_o, 1'b1);
        check_value("reset sclk", spi_sclk_o, 1'b0);
        check_value("reset mosi", spi_mosi_o, 1'b0);
        check_value("reset pending", i2c_pending_o, 1'b0);
    endtask

    task automatic test_sram_round_trip();
        logic [31:0] a, d;
        for (int i = 0; i < 8; i++) begin
            a = rand_bits(9) << 2;   // word aligned, below 2048
            d = rand_bits(32);
            sram_sb[a] = d;
            handler_write(a, d);
        end
        check_sram_contents("sram");
    endtask

    task automatic test_unmapped();
        logic [31:0] addrs [3];
        logic [31:0] d;
        sram_sb[32'h0] = rand_bits(32);   // 2048 and 2052 must not alias onto words 0 and 1
        sram_sb[32'h4] = rand_bits(32);
        handler_write(32'h0, sram_sb[32'h0]);
        handler_write(32'h4, sram_sb[32'h4]);
        addrs[0] = SRAM_LIMIT;
        addrs[1] = SRAM_LIMIT + 32'd4;
        addrs[2] = (rand_bits(32) | 32'h0010_0000) & ~32'h3;   // above every register
        foreach (addrs[i]) begin
            handler_read(addrs[i], d);
            check_value($sformatf("unmapped read %h", addrs[i]), d, 32'h0);
            handler_write(addrs[i], rand_bits(32));
        end
        check_sram_contents("after unmapped");
    endtask

    task automatic test_spi_transfer(input int iter);
        logic [7:0]  cmd;
        int          cnt;
        logic [31:0] param;
        logic [63:0] stream;
        int          nbits;
        time         end_t;
        cmd   = rand_bits(8);
        cnt   = rand_bits(3) % 5;
        param = rand_bits(32);
        handler_write(SPI_CMD_ADDR, {20'd0, 4'(cnt), cmd});
        fork
            handler_write(SPI_PARAM_ADDR, param);
            collect_spi(stream, nbits, end_t);
        join
        check_spi_frame($sformatf("spi %0d", iter), cmd, cnt, param, stream, nbits);
    endtask

    task automatic test_spi_backpressure();
        logic [7:0]  cmd;
        logic [31:0] p1, p2;
        logic [63:0] s1, s2;
        int          n1, n2;
        time         end1, end2, p2_done;
        cmd = rand_bits(8);
        p1  = rand_bits(32);
        p2  = rand_bits(32);
        handler_write(SPI_CMD_ADDR, {20'd0, 4'd4, cmd});
        fork
            begin
                handler_write(SPI_PARAM_ADDR, p1);
                handler_write(SPI_PARAM_ADDR, p2);   // stalls behind frame 1
                p2_done = $time;
            end
            begin
                collect_spi(s1, n1, end1);
                collect_spi(s2, n2, end2);
            end
        join
        check_spi_frame("spi frame 1", cmd, 4, p1, s1, n1);
        check_spi_frame("spi frame 2", cmd, 4, p2, s2, n2);
        check_value("spi stall", p2_done > end1, 1'b1);
    endtask

    task automatic test_touch_read();
        logic [31:0] xy, got;
        xy = rand_bits(32);
        check_value("touch pending before", i2c_pending_o, 1'b0);
        fork
            handler_read(TOUCH_ADDR, got);
            begin
                repeat (20) @(posedge clk);
                check_value("touch stall busy", busy_o, 1'b1);   // no coordinate yet
                i2c_xy_i   <= xy;
                i2c_done_i <= 1'b1;
                @(posedge clk);
                i2c_done_i <= 1'b0;
            end
        join
        check_value("touch xy", got, xy);
        check_value("touch pending after", i2c_pending_o, 1'b0);
    endtask

    task automatic test_conflict();
        bit rose;
        rose = 1'b0;
        sram_sb[32'h10] = rand_bits(32);   // a wrongly taken write would show here
        handler_write(32'h10, sram_sb[32'h10]);
        @(posedge clk);
        read_i    <= 1'b1;
        write_i   <= 1'b1;
        address_i <= 32'h10;
        wdata_i   <= ~sram_sb[32'h10];
        for (int n = 0; n < BUSY_TIMEOUT / 4; n++) begin
            @(posedge clk);
            if (busy_o !== 1'b0)
                rose = 1'b1;
        end
        read_i  <= 1'b0;
        write_i <= 1'b0;
        check_value("conflict busy", rose, 1'b0);
        check_sram_contents("after conflict");
    endtask

    initial begin
        nRst       = 1'b0;
        read_i     = 1'b0;
        write_i    = 1'b0;
        address_i  = '0;
        wdata_i    = '0;
        i2c_xy_i   = '0;
        i2c_done_i = 1'b0;
        repeat (10) @(posedge clk);
        nRst <= 1'b1;
        repeat (2) @(posedge clk);

        test_reset_values();
        test_sram_round_trip();
        test_unmapped();
        for (int i = 0; i < 4; i++)
            test_spi_transfer(i);
        test_spi_backpressure();
        test_touch_read();
        test_conflict();

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
logic/mmio_map_pkg.sv
logic/spi_reg_pkg.sv
logic/touch_latch.sv
logic/data_sram.sv
logic/spi_shifter.sv
logic/mmio_decoder.sv
logic/mmio_subsystem.sv
testbench/tb_mmio_subsystem.sv

// File: Bender.yml
package:
  name: mmio_subsystem

sources:
  # packages first, then the blocks, then the top level
  - logic/mmio_map_pkg.sv
  - logic/spi_reg_pkg.sv
  - logic/touch_latch.sv
  - logic/data_sram.sv
  - logic/spi_shifter.sv
  - logic/mmio_decoder.sv
  - logic/mmio_subsystem.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_mmio_subsystem.sv
